// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP   = cache_tb
FLIST = cache_top.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FLIST)

# the log decides pass or fail, grep sets the exit status
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== cache_top.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_way_if.sv
hdl/cache_way.sv
hdl/cache_hit_merge.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verif/cache_mem_model.sv
verif/cache_tb.sv

// ==== hdl/cache_ctrl.sv ====
/* cache controller */
`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_req,
  input  logic                     i_op,        // 0 read, 1 write
  input  logic [`CACHE_ADDR_W-1:0] i_addr,
  input  logic [63:0]              i_wdata,
  input  logic [2:0]               i_bytes,     // count minus one
  input  logic                     i_hit_any,
  input  logic                     i_mem_ready,
  input  logic [511:0]             i_mem_rdata,
  cache_way_if.ctrl                wif [`CACHE_WAYS],
  output logic                     o_respond,
  output logic [`CACHE_OFF_W-1:0]  o_byte_off,
  output logic [2:0]               o_bytes,
  output logic                     o_mem_valid,
  output logic                     o_mem_op,    // 0 read, 1 write
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [511:0]             o_mem_wdata
);

  localparam int WAY_W = $clog2(`CACHE_WAYS);

  ctrl_state_e state, state_nx;

  // request held for the whole transaction
  logic [`CACHE_TAG_W-1:0]      req_tag;
  logic [`CACHE_SET_W-1:0]      req_set;
  logic [`CACHE_OFF_W-1:0]      req_off;
  logic [2:0]                   req_bytes;
  logic                         req_op;
  logic [63:0]                  req_wdata;

  logic [WAY_W-1:0]             rr_ptr [`CACHE_SETS];
  logic [WAY_W-1:0]             victim;
  way_state_t                   victim_st;

  logic [`CACHE_WAYS-1:0]       way_hit;
  way_state_t                   way_st   [`CACHE_WAYS];
  cache_line_u                  way_line [`CACHE_WAYS];

  logic [7:0]                   lane_mask;
  logic [`CACHE_LINE_BYTES-1:0] byte_mask;
  cache_line_u                  wr_line;
  logic                         fill_done;
  logic                         wr_commit;

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && i_req) begin
      req_tag   <= i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
      req_set   <= i_addr[`CACHE_OFF_W +: `CACHE_SET_W];
      req_off   <= i_addr[`CACHE_OFF_W-1:0];
      req_bytes <= i_bytes;
      req_op    <= i_op;
      req_wdata <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE:    if (i_req) state_nx = ST_LOOKUP;
      ST_LOOKUP: begin
        if (i_hit_any) begin
          state_nx = ST_RESPOND;
        end else if (victim_st.valid && victim_st.dirty) begin
          state_nx = ST_WBACK;
        end else begin
          state_nx = ST_REFILL;
        end
      end
      ST_WBACK:   if (i_mem_ready) state_nx = ST_REFILL;
      ST_REFILL:  if (i_mem_ready) state_nx = ST_LOOKUP;  // second lookup now hits
      ST_RESPOND: state_nx = ST_IDLE;
      default:    state_nx = ST_IDLE;
    endcase
  end

  // round-robin victim per set
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        rr_ptr[s] <= '0;
      end
    end else if (fill_done) begin
      rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
    end
  end

  assign victim    = rr_ptr[req_set];
  assign victim_st = way_st[victim];

  assign fill_done = (state == ST_REFILL) && i_mem_ready;
  assign wr_commit = (state == ST_RESPOND) && req_op;

  // write data is right-aligned, move it to its byte offset
  assign lane_mask = 8'hff >> (3'd7 - req_bytes);
  assign byte_mask = {{(`CACHE_LINE_BYTES-8){1'b0}}, lane_mask} << req_off;
  assign wr_line   = {448'b0, req_wdata} << {req_off, 3'b000};

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    assign way_hit[w]  = wif[w].hit;
    assign way_st[w]   = wif[w].state_out;
    assign way_line[w] = wif[w].line_out;

    assign wif[w].set_idx   = req_set;
    assign wif[w].tag       = req_tag;
    assign wif[w].fill_en   = fill_done && (victim == WAY_W'(w));
    assign wif[w].wr_en     = wr_commit && way_hit[w];
    assign wif[w].byte_en   = byte_mask;
    assign wif[w].wr_line   = wr_line;
    assign wif[w].fill_line = i_mem_rdata;
    assign wif[w].new_state = '{valid: 1'b1, dirty: (state == ST_RESPOND), tag: req_tag};
  end

  assign o_respond  = (state == ST_LOOKUP) && i_hit_any;  // ack goes out next cycle
  assign o_byte_off = req_off;
  assign o_bytes    = req_bytes;

  assign o_mem_valid = (state == ST_WBACK) || (state == ST_REFILL);
  assign o_mem_op    = (state == ST_WBACK);
  assign o_mem_addr  = (state == ST_WBACK) ?
                       {victim_st.tag, req_set, {`CACHE_OFF_W{1'b0}}} :
                       {req_tag, req_set, {`CACHE_OFF_W{1'b0}}};
  assign o_mem_wdata = way_line[victim];

  a_mem_hold: assert property (
    @(posedge clk) disable iff (rst)
    o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr)
  );

  a_in_line: assert property (
    @(posedge clk) disable iff (rst)
    i_req |-> ({1'b0, i_addr[`CACHE_OFF_W-1:0]} + {4'b0, i_bytes}) < 7'd64
  );

endmodule

// ==== hdl/cache_defs.svh ====
/* cache geometry */

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width of the requester and memory port
`define CACHE_ADDR_W      64

// line size, one memory transfer
`define CACHE_LINE_BYTES  64

// sets per way
`define CACHE_SETS        16

// associativity
`define CACHE_WAYS        4

// address split
`define CACHE_OFF_W       6   // byte in line
`define CACHE_SET_W       4   // set index

// what is left over is tag, address width minus 10
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_SET_W - `CACHE_OFF_W)

`endif

// ==== hdl/cache_hit_merge.sv ====
/* hit select and read extract */
`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_hit_merge import cache_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  cache_way_if.merge              wif [`CACHE_WAYS],
  input  logic                    i_respond,
  input  logic [`CACHE_OFF_W-1:0] i_byte_off,
  input  logic [2:0]              i_bytes,
  output logic                    o_hit_any,
  output logic                    o_ack,
  output logic [63:0]             o_rdata
);

  logic [`CACHE_WAYS-1:0] hit_vec;
  cache_line_u            line_vec [`CACHE_WAYS];
  cache_line_u            sel_line;

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    assign hit_vec[w]  = wif[w].hit;
    assign line_vec[w] = wif[w].line_out;
  end

  assign o_hit_any = |hit_vec;

  always_comb begin
    sel_line = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hit_vec[w]) begin
        sel_line = line_vec[w];
      end
    end
  end

  // bytes+1 lanes from the offset, right-aligned, rest zero
  always_comb begin
    o_rdata = '0;
    for (int b = 0; b < 8; b++) begin
      if (b <= i_bytes) begin
        o_rdata[b*8 +: 8] = sel_line.bytes[i_byte_off + `CACHE_OFF_W'(b)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= i_respond;   // one cycle pulse
    end
  end

  a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

// ==== hdl/cache_pkg.sv ====
/* cache types */

`include "cache_defs.svh"

package cache_pkg;

  // one line as seen by the memory port and by the byte merge
  typedef union packed {
    logic [`CACHE_LINE_BYTES/8-1:0][63:0] words;  // 8 bus words
    logic [`CACHE_LINE_BYTES-1:0][7:0]    bytes;  // byte lanes, lane 0 lowest
  } cache_line_u;

  // per set bookkeeping held in each way
  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [`CACHE_TAG_W-1:0] tag;
  } way_state_t;

  // controller sequence
  // idle -> lookup -> respond on a hit
  // lookup -> [wback] -> refill -> lookup on a miss
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WBACK,     // dirty victim to memory
    ST_REFILL,    // new line from memory
    ST_RESPOND
  } ctrl_state_e;

endpackage

// ==== hdl/cache_top.sv ====
/* data cache top */
`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_top (
  input  logic                     clk,
  input  logic                     rst,
  // requester
  input  logic                     i_req,
  input  logic                     i_op,
  input  logic [`CACHE_ADDR_W-1:0] i_addr,
  input  logic [63:0]              i_wdata,
  input  logic [2:0]               i_bytes,
  output logic                     o_ack,
  output logic [63:0]              o_rdata,
  // line memory
  input  logic                     i_mem_ready,
  input  logic [511:0]             i_mem_rdata,
  output logic                     o_mem_valid,
  output logic                     o_mem_op,
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [511:0]             o_mem_wdata
);

  logic                    hit_any;
  logic                    respond;
  logic [`CACHE_OFF_W-1:0] byte_off;
  logic [2:0]              bytes;

  cache_way_if way_if [`CACHE_WAYS] ();

  cache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_req),
    .i_op        (i_op),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_bytes     (i_bytes),
    .i_hit_any   (hit_any),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata),
    .wif         (way_if),
    .o_respond   (respond),
    .o_byte_off  (byte_off),
    .o_bytes     (bytes),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata)
  );

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    cache_way u_way (
      .clk (clk),
      .rst (rst),
      .wif (way_if[w])
    );
  end

  cache_hit_merge u_merge (
    .clk        (clk),
    .rst        (rst),
    .wif        (way_if),
    .i_respond  (respond),
    .i_byte_off (byte_off),
    .i_bytes    (bytes),
    .o_hit_any  (hit_any),
    .o_ack      (o_ack),
    .o_rdata    (o_rdata)
  );

endmodule

// ==== hdl/cache_way.sv ====
/* one cache way */
`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_way import cache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  cache_way_if.way   wif
);

  way_state_t  state_mem [`CACHE_SETS];
  cache_line_u line_mem  [`CACHE_SETS];

  way_state_t  cur_state;

  // read port is purely combinational on the set index
  assign cur_state     = state_mem[wif.set_idx];
  assign wif.state_out = cur_state;
  assign wif.line_out  = line_mem[wif.set_idx];

  assign wif.hit = cur_state.valid && (cur_state.tag == wif.tag);

  // valid, dirty and tag
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        state_mem[s] <= '0;   // all lines invalid and clean
      end
    end else if (wif.fill_en || wif.wr_en) begin
      state_mem[wif.set_idx] <= wif.new_state;
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if (wif.fill_en) begin
      line_mem[wif.set_idx] <= wif.fill_line;
    end else if (wif.wr_en) begin
      for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
        if (wif.byte_en[b]) begin
          line_mem[wif.set_idx].bytes[b] <= wif.wr_line.bytes[b];
        end
      end
    end
  end

  // the controller only ever fills a victim or writes a hit line
  a_fill_xor_write: assert property (
    @(posedge clk) disable iff (rst)
    !(wif.fill_en && wif.wr_en)
  );

endmodule

// ==== hdl/cache_way_if.sv ====
/* way access bundle */
`timescale 1ns/1ns

`include "cache_defs.svh"

interface cache_way_if import cache_pkg::*; ();

  // from the controller
  logic [`CACHE_SET_W-1:0]      set_idx;
  logic [`CACHE_TAG_W-1:0]      tag;        // lookup tag
  logic                         wr_en;      // byte masked write
  logic                         fill_en;    // whole line refill
  logic [`CACHE_LINE_BYTES-1:0] byte_en;
  cache_line_u                  wr_line;
  cache_line_u                  fill_line;
  way_state_t                   new_state;  // written with either enable

  // from the way
  logic                         hit;
  way_state_t                   state_out;
  cache_line_u                  line_out;

  modport ctrl (
    output set_idx, tag, wr_en, fill_en, byte_en, wr_line, fill_line, new_state,
    input  hit, state_out, line_out
  );

  modport way (
    input  set_idx, tag, wr_en, fill_en, byte_en, wr_line, fill_line, new_state,
    output hit, state_out, line_out
  );

  // read side only
  modport merge (
    input  hit, line_out
  );

endinterface

// ==== verif/cache_mem_model.sv ====
/* line memory model */
`timescale 1ns/1ns

module cache_mem_model (
  input  logic         clk,
  input  logic         rst,
  input  logic         i_valid,
  input  logic         i_op,       // 1 write
  input  logic [63:0]  i_addr,
  input  logic [511:0] i_wdata,
  output logic         o_ready,
  output logic [511:0] o_rdata,
  output int           o_wr_count  // line write-backs seen
);

  logic [511:0] lines [logic [57:0]];  // keyed by line number
  integer       seed = 89549;
  logic         busy;
  int           wait_cnt;

  // xor fold over every address byte
  function automatic logic [7:0] addr_pattern(input logic [63:0] a);
    logic [7:0] v;
    v = 8'h3c;
    for (int i = 0; i < 8; i++) begin
      v ^= a[i*8 +: 8];
    end
    return v;
  endfunction

  function automatic logic [511:0] read_line(input logic [63:0] a);
    logic [511:0] l;
    if (lines.exists(a[63:6])) begin
      return lines[a[63:6]];
    end
    for (int b = 0; b < 64; b++) begin
      l[b*8 +: 8] = addr_pattern({a[63:6], 6'd0} + 64'(b));
    end
    return l;
  endfunction

  initial begin
    o_ready    <= 1'b0;
    o_rdata    <= '0;
    o_wr_count <= 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      o_ready    <= 1'b0;
      o_rdata    <= '0;
      o_wr_count <= 0;
      busy       <= 1'b0;
      wait_cnt   <= 0;
    end else if (o_ready) begin
      o_ready <= 1'b0;   // handshake taken at this edge
      if (i_valid && i_op) begin
        lines[i_addr[63:6]] = i_wdata;
        o_wr_count <= o_wr_count + 1;
      end
    end else if (i_valid) begin
      if (!busy) begin
        busy     <= 1'b1;
        wait_cnt <= $unsigned($random(seed)) % 6;
      end else if (wait_cnt == 0) begin
        o_ready <= 1'b1;
        o_rdata <= read_line(i_addr);
        busy    <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// ==== verif/cache_tb.sv ====
/* data cache testbench */
`timescale 1ns/1ns

module cache_tb;

  localparam int ACK_TIMEOUT = 200;   // negedges per access

  logic         clk = 1'b0;
  logic         rst;
  logic         i_req;
  logic         i_op;
  logic [63:0]  i_addr;
  logic [63:0]  i_wdata;
  logic [2:0]   i_bytes;
  logic         o_ack;
  logic [63:0]  o_rdata;
  logic         mem_ready;
  logic [511:0] mem_rdata;
  logic         mem_valid;
  logic         mem_op;
  logic [63:0]  mem_addr;
  logic [511:0] mem_wdata;
  int           mem_writes;

  logic [7:0]   ref_mem [logic [63:0]];  // bytes written so far
  integer       seed = 89549;
  int           errors = 0;
  int           timeouts = 0;
  int           reads = 0;
  string        chk_name;
  logic         chk_read = 1'b0;         // current access is a read
  logic [63:0]  chk_exp;

  always #2 clk = ~clk;

  cache_top dut0 (
    .clk (clk), .rst (rst),
    .i_req (i_req), .i_op (i_op), .i_addr (i_addr), .i_wdata (i_wdata), .i_bytes (i_bytes),
    .o_ack (o_ack), .o_rdata (o_rdata),
    .i_mem_ready (mem_ready), .i_mem_rdata (mem_rdata),
    .o_mem_valid (mem_valid), .o_mem_op (mem_op), .o_mem_addr (mem_addr),
    .o_mem_wdata (mem_wdata)
  );

  cache_mem_model mem0 (
    .clk (clk), .rst (rst),
    .i_valid (mem_valid), .i_op (mem_op), .i_addr (mem_addr), .i_wdata (mem_wdata),
    .o_ready (mem_ready), .o_rdata (mem_rdata), .o_wr_count (mem_writes)
  );

  // same fold as the memory model
  function automatic logic [7:0] addr_pattern(input logic [63:0] a);
    logic [7:0] v;
    v = 8'h3c;
    for (int i = 0; i < 8; i++) begin
      v ^= a[i*8 +: 8];
    end
    return v;
  endfunction

  function automatic logic [63:0] ref_read(input logic [63:0] addr, input logic [2:0] nbytes);
    logic [63:0] r;
    logic [63:0] a;
    r = '0;
    for (int k = 0; k < 8; k++) begin
      if (k <= int'(nbytes)) begin
        a = addr + 64'(k);
        r[k*8 +: 8] = ref_mem.exists(a) ? ref_mem[a] : addr_pattern(a);
      end
    end
    return r;
  endfunction

  task automatic ref_write(input logic [63:0] addr, input logic [63:0] data,
                           input logic [2:0] nbytes);
    for (int k = 0; k <= int'(nbytes); k++) begin
      ref_mem[addr + 64'(k)] = data[k*8 +: 8];
    end
  endtask

  task automatic finish_run();
    $display("checked %0d reads, errors=%0d timeouts=%0d", reads, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // one request held until its ack
  task automatic access(input string name, input logic op, input logic [63:0] addr,
                        input logic [63:0] wdata, input logic [2:0] nbytes, output int lat);
    int waited;
    chk_name = name;
    chk_read = !op;
    if (op) ref_write(addr, wdata, nbytes);
    else chk_exp = ref_read(addr, nbytes);
    @(posedge clk);
    i_req   <= 1'b1;
    i_op    <= op;
    i_addr  <= addr;
    i_wdata <= wdata;
    i_bytes <= nbytes;
    lat    = 0;   // edges from request to ack
    waited = 0;
    @(negedge clk);
    while (!o_ack && waited < ACK_TIMEOUT) begin
      lat++;
      waited++;
      @(negedge clk);
    end
    if (!o_ack) begin
      $display("no ack within %0d cycles for %s at address %h", ACK_TIMEOUT, name, addr);
      timeouts++;
    end
    @(posedge clk);
    i_req    <= 1'b0;
    chk_read = 1'b0;
  endtask

  // read data checked where it is stable
  always @(negedge clk) begin
    if (o_ack && chk_read) begin
      reads++;
      if (o_rdata !== chk_exp) begin
        errors++;
        $display("[ERROR] %s expected %h actual %h", chk_name, chk_exp, o_rdata);
      end
    end
  end

  initial begin
    int          lat;
    int          wr_before;
    logic [31:0] r;
    logic [31:0] r2;
    logic [63:0] addr;
    logic [63:0] base;
    logic [5:0]  off;
    rst     <= 1'b1;
    i_req   <= 1'b0;
    i_op    <= 1'b0;
    i_addr  <= '0;
    i_wdata <= '0;
    i_bytes <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    repeat (3) begin
      @(negedge clk);
      if (o_ack !== 1'b0) begin
        errors++;
        $display("[ERROR] reset_ack expected 0 actual %b", o_ack);
      end
      if (mem_valid !== 1'b0) begin
        errors++;
        $display("[ERROR] reset_mem_valid expected 0 actual %b", mem_valid);
      end
    end

    base = 64'h0000_0040_0000_1140;   // set 5
    access("write_read", 1'b1, base, 64'h0123_4567_89ab_cdef, 3'd7, lat);
    access("write_read", 1'b0, base, '0, 3'd7, lat);
    if (lat != 2) begin
      errors++;
      $display("[ERROR] hit_latency expected 2 actual %0d", lat);
    end

    access("partial_bytes", 1'b1, base + 64'd1, 64'h0000_00aa, 3'd0, lat);
    access("partial_bytes", 1'b1, base + 64'd2, 64'h0000_bbcc, 3'd1, lat);
    access("partial_bytes", 1'b1, base + 64'd4, 64'h1122_3344, 3'd3, lat);
    access("partial_bytes", 1'b1, base + 64'd13, 64'h0000_5566, 3'd1, lat);
    access("partial_bytes", 1'b0, base, '0, 3'd7, lat);
    access("partial_bytes", 1'b0, base + 64'd1, '0, 3'd1, lat);
    access("partial_bytes", 1'b0, base + 64'd3, '0, 3'd3, lat);
    access("partial_bytes", 1'b0, base + 64'd12, '0, 3'd3, lat);
    access("partial_bytes", 1'b0, base + 64'd6, '0, 3'd2, lat);

    // five tags in set 9 to overflow four ways
    wr_before = mem_writes;
    for (int t = 1; t <= 5; t++) begin
      addr = 64'h0055_0000_0000_0240 | (64'(t) << 10);
      access("eviction", 1'b1, addr, {$random(seed), $random(seed)}, 3'd7, lat);
    end
    for (int t = 1; t <= 5; t++) begin
      addr = 64'h0055_0000_0000_0240 | (64'(t) << 10);
      access("eviction", 1'b0, addr, '0, 3'd7, lat);
    end
    if (mem_writes <= wr_before) begin
      errors++;
      $display("[ERROR] eviction_writeback expected above %0d actual %0d",
               wr_before, mem_writes);
    end

    // 16 tags times 4 sets
    for (int n = 0; n < 300; n++) begin
      r    = $random(seed);
      r2   = $random(seed);
      off  = 6'($unsigned(r2) % (64 - int'(r[2:0])));
      addr = 64'hA5A5_0000_0000_0000 | (64'(r[9:6]) << 10) | (64'(r[5:4]) << 6) | 64'(off);
      access("random_mix", r[3], addr, {$random(seed), $random(seed)}, r[2:0], lat);
    end

    finish_run();
  end

endmodule
